/* logic/end_screen_pkg.sv */
package end_screen_pkg;

    //////////////////////////////
    // Raster constants

    localparam int h_active = 640;
    localparam int v_active = 480;

    localparam int h_front_def = 16;
    localparam int h_sync_def = 96;
    localparam int h_back_def = 48;
    localparam int v_front_def = 10;
    localparam int v_sync_def = 2;
    localparam int v_back_def = 33;

    //////////////////////////////
    // Shared types

    typedef logic [9:0] coord_t;
    typedef logic [9:0] score_t;
    typedef logic [7:0] glyph_row_t;

    // Sync bits are active low
    typedef struct packed {
        coord_t x;
        coord_t y;
        logic active;
        logic hsync;
        logic vsync;
    } scan_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    typedef struct packed {
        logic hit;
        rgb_t color;
    } layer_t;

    typedef struct packed {
        logic signed [8:0] dx;
        logic signed [8:0] dy;
        logic left;
        logic right;
    } motion_t;

    //////////////////////////////
    // Layout and colours

    localparam coord_t banner_y = 10'd130;
    localparam coord_t banner_x [10] = '{10'd230, 10'd246, 10'd262, 10'd278, 10'd294,
                                         10'd318, 10'd334, 10'd350, 10'd366, 10'd382};

    localparam coord_t button_x0 = 10'd269;
    localparam coord_t button_x1 = 10'd360;
    localparam coord_t button_y0 = 10'd350;
    localparam coord_t button_y1 = 10'd370;

    localparam coord_t label_y = 10'd356;
    localparam coord_t label_x [7] = '{10'd275, 10'd286, 10'd298, 10'd310,
                                       10'd322, 10'd334, 10'd346};

    localparam coord_t digit_x [3] = '{10'd200, 10'd275, 10'd350};
    localparam coord_t digit_y = 10'd185;

    localparam coord_t pointer_size = 10'd16;
    localparam logic [3:0] banner_level = 4'd9;
    localparam logic [3:0] label_level = 4'd15;
    localparam rgb_t button_fill = '{r: 4'd0, g: 4'd6, b: 4'd12};

    //////////////////////////////
    // Font

    typedef enum logic [3:0] {
        ltr_f, ltr_i, ltr_n, ltr_a, ltr_l, ltr_s, ltr_c, ltr_o, ltr_r, ltr_e, ltr_t
    } letter_t;

    localparam letter_t banner_str [10] = '{ltr_f, ltr_i, ltr_n, ltr_a, ltr_l,
                                            ltr_s, ltr_c, ltr_o, ltr_r, ltr_e};
    localparam letter_t label_str [7] = '{ltr_r, ltr_e, ltr_s, ltr_t, ltr_a, ltr_r, ltr_t};

    // Row 0 sits in the low byte, column c is bit c of a row
    function automatic glyph_row_t glyph(letter_t code, logic [2:0] row);
        logic [63:0] bits;
        case (code)
            ltr_f: bits = 64'h00_08_08_08_78_08_08_F8;
            ltr_i: bits = 64'h00_38_10_10_10_10_10_38;
            ltr_n: bits = 64'h00_42_42_62_52_4A_46_42;
            ltr_a: bits = 64'h00_41_41_41_7F_41_41_3E;
            ltr_l: bits = 64'h00_3F_01_01_01_01_01_01;
            ltr_s: bits = 64'h00_3E_41_40_3E_01_41_3E;
            ltr_c: bits = 64'h00_3C_42_01_01_01_42_3C;
            ltr_o: bits = 64'h00_7C_82_82_82_82_82_7C;
            ltr_r: bits = 64'h00_41_21_11_1F_21_21_1F;
            ltr_e: bits = 64'h00_7E_02_02_7E_02_02_7E;
            ltr_t: bits = 64'h00_08_08_08_08_08_08_7F;
            default: bits = '0;
        endcase
        return bits[{row, 3'b000} +: 8];
    endfunction

endpackage

/* logic/raster_timing.sv */
`timescale 1ns/1ps

module raster_timing #(
    parameter int h_front = end_screen_pkg::h_front_def,
    parameter int h_sync = end_screen_pkg::h_sync_def,
    parameter int h_back = end_screen_pkg::h_back_def,
    parameter int v_front = end_screen_pkg::v_front_def,
    parameter int v_sync = end_screen_pkg::v_sync_def,
    parameter int v_back = end_screen_pkg::v_back_def
) (
    input  logic                  in_clk,
    input  logic                  reset,
    output end_screen_pkg::scan_t scan
);
    import end_screen_pkg::*;

    localparam int h_total = h_active + h_front + h_sync + h_back;
    localparam int v_total = v_active + v_front + v_sync + v_back;

    // Count order is active, front porch, sync, back porch
    localparam coord_t h_last = coord_t'(h_total - 1);
    localparam coord_t v_last = coord_t'(v_total - 1);
    localparam coord_t x_limit = coord_t'(h_active);
    localparam coord_t y_limit = coord_t'(v_active);
    localparam coord_t hs_start = coord_t'(h_active + h_front);
    localparam coord_t hs_stop = coord_t'(h_active + h_front + h_sync);
    localparam coord_t vs_start = coord_t'(v_active + v_front);
    localparam coord_t vs_stop = coord_t'(v_active + v_front + v_sync);

    coord_t h_next;
    coord_t v_next;

    // The scan position doubles as the counter pair
    always_comb begin
        h_next = scan.x + 10'd1;
        v_next = scan.y;
        if (scan.x == h_last) begin
            h_next = '0;
            if (scan.y == v_last) begin
                v_next = '0;
            end else begin
                v_next = scan.y + 10'd1;
            end
        end
    end

    //////////////////////////////
    // Scan register

    always_ff @(posedge in_clk or negedge reset) begin
        if (!reset) begin
            scan <= '{x: '0, y: '0, active: 1'b1, hsync: 1'b1, vsync: 1'b1};
        end else begin
            scan.x <= h_next;
            scan.y <= v_next;
            scan.active <= (h_next < x_limit) && (v_next < y_limit);
            // Flags follow the next count so they line up with x and y
            scan.hsync <= !((h_next >= hs_start) && (h_next < hs_stop));
            scan.vsync <= !((v_next >= vs_start) && (v_next < vs_stop));
        end
    end

endmodule

/* logic/banner_text.sv */
`timescale 1ns/1ps

module banner_text (
    input  logic                   in_clk,
    input  logic                   reset,
    input  end_screen_pkg::scan_t  scan,
    output end_screen_pkg::layer_t text
);
    import end_screen_pkg::*;

    localparam coord_t cell_size = 10'd8;

    logic banner_on;
    logic label_on;
    logic in_box;
    layer_t text_d;

    // True when (x, y) falls in the 8x8 cell at (x0, y0) on a set glyph bit
    function automatic logic cell_pixel(letter_t code, coord_t x0, coord_t y0,
                                        coord_t x, coord_t y);
        coord_t col;
        coord_t row;
        glyph_row_t bits;
        col = x - x0;
        row = y - y0;
        bits = glyph(code, row[2:0]);
        // Positions left of or above the cell wrap to large offsets
        return (col < cell_size) && (row < cell_size) && bits[col[2:0]];
    endfunction

    //////////////////////////////
    // Letter and box hit test

    always_comb begin
        banner_on = 1'b0;
        for (int i = 0; i < 10; i++) begin
            banner_on = banner_on | cell_pixel(banner_str[i], banner_x[i], banner_y,
                                               scan.x, scan.y);
        end

        label_on = 1'b0;
        for (int i = 0; i < 7; i++) begin
            label_on = label_on | cell_pixel(label_str[i], label_x[i], label_y,
                                             scan.x, scan.y);
        end

        in_box = (scan.x >= button_x0) && (scan.x < button_x1) &&
                 (scan.y >= button_y0) && (scan.y < button_y1);
    end

    always_comb begin
        text_d = '0;
        if (banner_on) begin
            text_d = '{hit: 1'b1,
                       color: '{r: banner_level, g: banner_level, b: banner_level}};
        end else if (in_box && label_on) begin
            text_d = '{hit: 1'b1,
                       color: '{r: label_level, g: label_level, b: label_level}};
        end else if (in_box) begin
            // Plain button background
            text_d = '{hit: 1'b1, color: button_fill};
        end
    end

    always_ff @(posedge in_clk or negedge reset) begin
        if (!reset) begin
            text <= '0;
        end else begin
            text <= text_d;
        end
    end

endmodule

/* logic/score_digits.sv */
`timescale 1ns/1ps

module score_digits (
    input  logic                   in_clk,
    input  logic                   reset,
    input  end_screen_pkg::scan_t  scan,
    input  end_screen_pkg::score_t score,
    output end_screen_pkg::layer_t digits
);
    import end_screen_pkg::*;

    localparam score_t score_max = 10'd999;
    localparam score_t ten = 10'd10;

    // Segment boxes relative to the digit origin from a at index 0 to g at index 6
    localparam coord_t seg_x0 [7] = '{10'd10, 10'd60, 10'd60, 10'd10, 10'd0, 10'd0, 10'd10};
    localparam coord_t seg_x1 [7] = '{10'd60, 10'd70, 10'd70, 10'd60, 10'd10, 10'd10, 10'd60};
    localparam coord_t seg_y0 [7] = '{10'd0, 10'd10, 10'd70, 10'd120, 10'd70, 10'd10, 10'd60};
    localparam coord_t seg_y1 [7] = '{10'd10, 10'd60, 10'd120, 10'd130, 10'd120, 10'd60, 10'd70};

    score_t capped;
    score_t tens_part;
    logic [3:0] digit_val [3];
    logic [6:0] segs [3];
    layer_t digits_d;

    // Segment order is {a, b, c, d, e, f, g}
    function automatic logic [6:0] seg_decode(logic [3:0] value);
        case (value)
            4'd0: return 7'b1111110;
            4'd1: return 7'b0110000;
            4'd2: return 7'b1101101;
            4'd3: return 7'b1111001;
            4'd4: return 7'b0110011;
            4'd5: return 7'b1011011;
            4'd6: return 7'b1011111;
            4'd7: return 7'b1110000;
            4'd8: return 7'b1111111;
            4'd9: return 7'b1111011;
            default: return 7'b0000000;
        endcase
    endfunction

    //////////////////////////////
    // Decimal split

    always_comb begin
        capped = (score > score_max) ? score_max : score;
        tens_part = capped / ten;
        digit_val[0] = 4'(tens_part / ten);
        digit_val[1] = 4'(tens_part % ten);
        digit_val[2] = 4'(capped % ten);
        for (int k = 0; k < 3; k++) begin
            segs[k] = seg_decode(digit_val[k]);
        end
    end

    // Boxes do not overlap so at most one segment matches
    always_comb begin
        coord_t rel_x;
        coord_t rel_y;
        digits_d = '0;
        rel_y = scan.y - digit_y;
        for (int k = 0; k < 3; k++) begin
            rel_x = scan.x - digit_x[k];
            for (int s = 0; s < 7; s++) begin
                if ((rel_x >= seg_x0[s]) && (rel_x < seg_x1[s]) &&
                    (rel_y >= seg_y0[s]) && (rel_y < seg_y1[s])) begin
                    digits_d.hit = 1'b1;
                    digits_d.color = '{r: {4{segs[k][6-s]}},
                                       g: {4{segs[k][6-s]}},
                                       b: {4{segs[k][6-s]}}};
                end
            end
        end
    end

    always_ff @(posedge in_clk or negedge reset) begin
        if (!reset) begin
            digits <= '0;
        end else begin
            digits <= digits_d;
        end
    end

endmodule

/* logic/pointer_tracker.sv */
`timescale 1ns/1ps

module pointer_tracker (
    input  logic                    in_clk,
    input  logic                    reset,
    input  end_screen_pkg::motion_t motion,
    input  logic                    motion_valid,
    output end_screen_pkg::coord_t  pointer_x,
    output end_screen_pkg::coord_t  pointer_y,
    output logic [2:0]              pointer_color,
    output logic                    restart
);
    import end_screen_pkg::*;

    localparam coord_t x_max = coord_t'(h_active - 1);
    localparam coord_t y_max = coord_t'(v_active - 1);

    logic signed [11:0] sum_x;
    logic signed [11:0] sum_y;
    logic in_button;

    // Keep the pointer on screen instead of wrapping
    function automatic coord_t clamp(logic signed [11:0] value, coord_t limit);
        if (value < 0) begin
            return '0;
        end
        if (value > $signed({2'b00, limit})) begin
            return limit;
        end
        return value[9:0];
    endfunction

    // Screen y grows downward, mouse dy grows upward
    assign sum_x = $signed({2'b00, pointer_x}) + $signed({{3{motion.dx[8]}}, motion.dx});
    assign sum_y = $signed({2'b00, pointer_y}) - $signed({{3{motion.dy[8]}}, motion.dy});

    assign in_button = (pointer_x >= button_x0) && (pointer_x < button_x1) &&
                       (pointer_y >= button_y0) && (pointer_y < button_y1);

    always_ff @(posedge in_clk or negedge reset) begin
        if (!reset) begin
            pointer_x <= '0;
            pointer_y <= '0;
            pointer_color <= 3'd3;
            restart <= 1'b0;
        end else if (motion_valid) begin
            pointer_x <= clamp(sum_x, x_max);
            pointer_y <= clamp(sum_y, y_max);

            // Right click wins over left click
            if (motion.right) begin
                pointer_color <= pointer_color + 3'd1;
            end else if (motion.left) begin
                pointer_color <= pointer_color - 3'd1;
            end

            // Click is judged at the position before the move
            if (!motion.left) begin
                restart <= 1'b0;
            end else if (in_button) begin
                restart <= 1'b1;
            end
        end
    end

endmodule

/* logic/pixel_mixer.sv */
`timescale 1ns/1ps

module pixel_mixer (
    input  logic                   in_clk,
    input  logic                   reset,
    input  end_screen_pkg::scan_t  scan,
    input  end_screen_pkg::layer_t text,
    input  end_screen_pkg::layer_t digits,
    input  end_screen_pkg::coord_t pointer_x,
    input  end_screen_pkg::coord_t pointer_y,
    input  logic [2:0]             pointer_color,
    output logic [3:0]             vga_r,
    output logic [3:0]             vga_g,
    output logic [3:0]             vga_b,
    output logic                   vga_hs,
    output logic                   vga_vs
);
    import end_screen_pkg::*;

    scan_t scan_d1;
    logic on_pointer;
    rgb_t pixel;

    // Lines the scan up with the registered layers
    always_ff @(posedge in_clk or negedge reset) begin
        if (!reset) begin
            scan_d1 <= '{x: '0, y: '0, active: 1'b0, hsync: 1'b1, vsync: 1'b1};
        end else begin
            scan_d1 <= scan;
        end
    end

    assign on_pointer = (scan_d1.x >= pointer_x) && (scan_d1.x < pointer_x + pointer_size) &&
                        (scan_d1.y >= pointer_y) && (scan_d1.y < pointer_y + pointer_size);

    //////////////////////////////
    // Layer priority

    always_comb begin
        pixel = '0;
        if (!scan_d1.active) begin
            pixel = '0;
        end else if (on_pointer) begin
            pixel = '{r: {4{pointer_color[0]}}, g: {4{pointer_color[1]}},
                      b: {4{pointer_color[2]}}};
        end else if (digits.hit) begin
            pixel = digits.color;
        end else if (text.hit) begin
            pixel = text.color;
        end
    end

    always_ff @(posedge in_clk or negedge reset) begin
        if (!reset) begin
            vga_r <= '0;
            vga_g <= '0;
            vga_b <= '0;
            vga_hs <= 1'b1;
            vga_vs <= 1'b1;
        end else begin
            vga_r <= pixel.r;
            vga_g <= pixel.g;
            vga_b <= pixel.b;
            vga_hs <= scan_d1.hsync;
            vga_vs <= scan_d1.vsync;
        end
    end

endmodule

/* logic/end_screen_top.sv */
`timescale 1ns/1ps

module end_screen_top #(
    parameter int h_front = end_screen_pkg::h_front_def,
    parameter int h_sync = end_screen_pkg::h_sync_def,
    parameter int h_back = end_screen_pkg::h_back_def,
    parameter int v_front = end_screen_pkg::v_front_def,
    parameter int v_sync = end_screen_pkg::v_sync_def,
    parameter int v_back = end_screen_pkg::v_back_def
) (
    input  logic                    in_clk,
    input  logic                    reset,
    input  end_screen_pkg::motion_t motion,
    input  logic                    motion_valid,
    input  end_screen_pkg::score_t  score,
    output logic [3:0]              vga_r,
    output logic [3:0]              vga_g,
    output logic [3:0]              vga_b,
    output logic                    vga_hs,
    output logic                    vga_vs,
    output logic                    restart
);
    import end_screen_pkg::*;

    scan_t scan;
    layer_t text;
    layer_t digits;
    coord_t pointer_x;
    coord_t pointer_y;
    logic [2:0] pointer_color;

    //////////////////////////////
    // Raster and layers

    raster_timing #(
        .h_front (h_front),
        .h_sync  (h_sync),
        .h_back  (h_back),
        .v_front (v_front),
        .v_sync  (v_sync),
        .v_back  (v_back)
    ) u_timing (
        .in_clk (in_clk),
        .reset  (reset),
        .scan   (scan)
    );

    banner_text u_text (
        .in_clk (in_clk),
        .reset  (reset),
        .scan   (scan),
        .text   (text)
    );

    score_digits u_digits (
        .in_clk (in_clk),
        .reset  (reset),
        .scan   (scan),
        .score  (score),
        .digits (digits)
    );

    // Pointer runs off the motion strobe, not the raster
    pointer_tracker u_pointer (
        .in_clk        (in_clk),
        .reset         (reset),
        .motion        (motion),
        .motion_valid  (motion_valid),
        .pointer_x     (pointer_x),
        .pointer_y     (pointer_y),
        .pointer_color (pointer_color),
        .restart       (restart)
    );

    pixel_mixer u_mixer (
        .in_clk        (in_clk),
        .reset         (reset),
        .scan          (scan),
        .text          (text),
        .digits        (digits),
        .pointer_x     (pointer_x),
        .pointer_y     (pointer_y),
        .pointer_color (pointer_color),
        .vga_r         (vga_r),
        .vga_g         (vga_g),
        .vga_b         (vga_b),
        .vga_hs        (vga_hs),
        .vga_vs        (vga_vs)
    );

endmodule

/* test/end_screen_tb.sv */
`timescale 1ns/1ps

module end_screen_tb;
    import end_screen_pkg::*;

    localparam int h_total = 800;
    localparam int v_total = 525;
    localparam int wait_limit = 500000;

    //////////////////////////////
    // Expected layout

    localparam int banner_origin [10] = '{230, 246, 262, 278, 294, 318, 334, 350, 366, 382};
    localparam int label_origin [7] = '{275, 286, 298, 310, 322, 334, 346};
    localparam int digit_origin [3] = '{200, 275, 350};
    // Segment centres from the digit origin in order a to g
    localparam int seg_cx [7] = '{35, 65, 65, 35, 5, 5, 35};
    localparam int seg_cy [7] = '{5, 35, 95, 125, 95, 35, 65};
    // Bit 6 is segment a, bit 0 is segment g
    localparam logic [6:0] seg_table [10] = '{7'h7e, 7'h30, 7'h6d, 7'h79, 7'h33,
                                             7'h5b, 7'h5f, 7'h70, 7'h7f, 7'h7b};
    // Row 0 in the low byte, column c is bit c
    localparam logic [63:0] banner_font [10] = '{
        64'h00_08_08_08_78_08_08_F8, 64'h00_38_10_10_10_10_10_38,
        64'h00_42_42_62_52_4A_46_42, 64'h00_41_41_41_7F_41_41_3E,
        64'h00_3F_01_01_01_01_01_01, 64'h00_3E_41_40_3E_01_41_3E,
        64'h00_3C_42_01_01_01_42_3C, 64'h00_7C_82_82_82_82_82_7C,
        64'h00_41_21_11_1F_21_21_1F, 64'h00_7E_02_02_7E_02_02_7E};
    localparam logic [63:0] label_font [7] = '{
        64'h00_41_21_11_1F_21_21_1F, 64'h00_7E_02_02_7E_02_02_7E,
        64'h00_3E_41_40_3E_01_41_3E, 64'h00_08_08_08_08_08_08_7F,
        64'h00_41_41_41_7F_41_41_3E, 64'h00_41_21_11_1F_21_21_1F,
        64'h00_08_08_08_08_08_08_7F};

    logic in_clk;
    logic reset;
    motion_t motion;
    logic motion_valid;
    score_t score;
    logic [3:0] vga_r, vga_g, vga_b;
    logic vga_hs, vga_vs, restart;
    logic [11:0] pix;

    // Pin position rebuilt from the sync edges
    int last_x, last_y, cur_x, cur_y;
    logic last_hs, last_vs, hs_rise, hs_fall, vs_rise, vs_fall;
    int hs_low, hs_per, vs_low, vs_per;
    logic hs_seen, vs_seen, h_lock, v_lock;

    // Pointer model
    int m_x, m_y;
    logic [2:0] m_col;
    logic m_restart;

    logic in_active, on_ptr, banner_probe, banner_bit, in_box, label_bit;
    logic seg_probe, seg_lit;
    logic [11:0] ptr_rgb, seg_rgb, banner_rgb, box_rgb;

    end_screen_top dut0 (
        .in_clk       (in_clk),
        .reset        (reset),
        .motion       (motion),
        .motion_valid (motion_valid),
        .score        (score),
        .vga_r        (vga_r),
        .vga_g        (vga_g),
        .vga_b        (vga_b),
        .vga_hs       (vga_hs),
        .vga_vs       (vga_vs),
        .restart      (restart)
    );

    always #20 in_clk = ~in_clk;

    assign pix = {vga_r, vga_g, vga_b};

    function automatic logic font_bit(logic [63:0] rows, int col, int row);
        logic [5:0] idx;
        idx = 6'(row * 8 + col);
        return rows[idx];
    endfunction

    function automatic int limit_step(int value);
        return (value > 255) ? 255 : ((value < -255) ? -255 : value);
    endfunction

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic value_error(input string name, input int got, input int expected);
        $display("Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, expected);
        abort_run();
    endtask

    //////////////////////////////
    // Raster tracking

    always_comb begin
        hs_rise = !last_hs && vga_hs;
        hs_fall = last_hs && !vga_hs;
        vs_rise = !last_vs && vga_vs;
        vs_fall = last_vs && !vga_vs;
        // Pixel 0 comes h_back cycles after the rising hsync
        cur_x = (last_x == h_total - 1) ? 0 : last_x + 1;
        if (hs_rise) begin
            cur_x = 752;
        end
        cur_y = last_y;
        if (cur_x == 0) begin
            cur_y = (last_y == v_total - 1) ? 0 : last_y + 1;
        end
        if (vs_rise) begin
            cur_y = 492;
        end
    end

    always @(posedge in_clk or negedge reset) begin
        if (!reset) begin
            {last_hs, last_vs} <= 2'b11;
            {hs_seen, vs_seen, h_lock, v_lock} <= 4'b0000;
            last_x <= 0;
            last_y <= 0;
            hs_low <= 0;
            vs_low <= 0;
            hs_per <= 0;
            vs_per <= 0;
        end else begin
            last_hs <= vga_hs;
            last_vs <= vga_vs;
            last_x <= cur_x;
            last_y <= cur_y;
            hs_low <= vga_hs ? 0 : hs_low + 1;
            vs_low <= vga_vs ? 0 : vs_low + 1;
            hs_per <= hs_fall ? 1 : hs_per + 1;
            vs_per <= vs_fall ? 1 : vs_per + 1;
            hs_seen <= hs_seen | hs_fall;
            vs_seen <= vs_seen | vs_fall;
            h_lock <= h_lock | hs_rise;
            v_lock <= v_lock | (vs_rise & h_lock);
        end
    end

    // Clamped move, colour step and restart on the position before the move
    always @(posedge in_clk or negedge reset) begin
        int nx;
        int ny;
        if (!reset) begin
            m_x <= 0;
            m_y <= 0;
            m_col <= 3'd3;
            m_restart <= 1'b0;
        end else if (motion_valid) begin
            nx = m_x + int'($signed(motion.dx));
            ny = m_y - int'($signed(motion.dy));
            m_x <= (nx < 0) ? 0 : ((nx > 639) ? 639 : nx);
            m_y <= (ny < 0) ? 0 : ((ny > 479) ? 479 : ny);
            if (motion.right) begin
                m_col <= m_col + 3'd1;
            end else if (motion.left) begin
                m_col <= m_col - 3'd1;
            end
            if (!motion.left) begin
                m_restart <= 1'b0;
            end else if (m_x >= 269 && m_x < 360 && m_y >= 350 && m_y < 370) begin
                m_restart <= 1'b1;
            end
        end
    end

    //////////////////////////////
    // Expected pixel

    always_comb begin
        int capped;
        int digit [3];
        in_active = (cur_x < 640) && (cur_y < 480);
        on_ptr = in_active && (cur_x >= m_x) && (cur_x < m_x + 16) &&
                 (cur_y >= m_y) && (cur_y < m_y + 16);
        ptr_rgb = {{4{m_col[0]}}, {4{m_col[1]}}, {4{m_col[2]}}};
        {banner_probe, banner_bit, label_bit, seg_probe, seg_lit} = 5'b00000;
        for (int i = 0; i < 10; i++) begin
            if (cur_x >= banner_origin[i] && cur_x < banner_origin[i] + 8 &&
                cur_y >= 130 && cur_y < 138) begin
                banner_probe = 1'b1;
                banner_bit = font_bit(banner_font[i], cur_x - banner_origin[i], cur_y - 130);
            end
        end
        in_box = (cur_x >= 269) && (cur_x < 360) && (cur_y >= 350) && (cur_y < 370);
        for (int i = 0; i < 7; i++) begin
            if (cur_x >= label_origin[i] && cur_x < label_origin[i] + 8 &&
                cur_y >= 356 && cur_y < 364) begin
                label_bit = font_bit(label_font[i], cur_x - label_origin[i], cur_y - 356);
            end
        end
        // Scores past 999 saturate
        capped = (score > 10'd999) ? 999 : int'(score);
        digit[0] = capped / 100;
        digit[1] = (capped / 10) % 10;
        digit[2] = capped % 10;
        for (int k = 0; k < 3; k++) begin
            for (int s = 0; s < 7; s++) begin
                if (cur_x == digit_origin[k] + seg_cx[s] && cur_y == 185 + seg_cy[s]) begin
                    seg_probe = 1'b1;
                    seg_lit = seg_table[digit[k]][3'(6 - s)];
                end
            end
        end
        seg_rgb = seg_lit ? 12'hfff : 12'h000;
        banner_rgb = banner_bit ? 12'h999 : 12'h000;
        box_rgb = label_bit ? 12'hfff : 12'h06c;
    end

    //////////////////////////////
    // Checks

    assert property (@(posedge in_clk) $rose(reset) |-> (vga_hs && vga_vs && pix == 12'h000))
        else value_error("{vga_hs, vga_vs, rgb}", $sampled({vga_hs, vga_vs, pix}), 14'h3000);
    assert property (@(posedge in_clk) disable iff (!reset) hs_rise |-> hs_low == 96)
        else value_error("vga_hs low cycles", $sampled(hs_low), 96);
    assert property (@(posedge in_clk) disable iff (!reset)
                     (hs_fall && hs_seen) |-> hs_per == h_total)
        else value_error("vga_hs period", $sampled(hs_per), h_total);
    assert property (@(posedge in_clk) disable iff (!reset) vs_rise |-> vs_low == 2 * h_total)
        else value_error("vga_vs low cycles", $sampled(vs_low), 2 * h_total);
    assert property (@(posedge in_clk) disable iff (!reset)
                     (vs_fall && vs_seen) |-> vs_per == h_total * v_total)
        else value_error("vga_vs period", $sampled(vs_per), h_total * v_total);
    assert property (@(posedge in_clk) disable iff (!reset)
                     (v_lock && !in_active) |-> pix == 12'h000)
        else value_error("rgb in blanking", $sampled(pix), 0);
    assert property (@(posedge in_clk) disable iff (!reset) (v_lock && on_ptr) |-> pix == ptr_rgb)
        else value_error("rgb on pointer", $sampled(pix), $sampled(ptr_rgb));
    assert property (@(posedge in_clk) disable iff (!reset)
                     (v_lock && !on_ptr && seg_probe) |-> pix == seg_rgb)
        else value_error("rgb on segment", $sampled(pix), $sampled(seg_rgb));
    assert property (@(posedge in_clk) disable iff (!reset)
                     (v_lock && !on_ptr && banner_probe) |-> pix == banner_rgb)
        else value_error("rgb on banner", $sampled(pix), $sampled(banner_rgb));
    assert property (@(posedge in_clk) disable iff (!reset)
                     (v_lock && !on_ptr && in_box) |-> pix == box_rgb)
        else value_error("rgb on button", $sampled(pix), $sampled(box_rgb));
    assert property (@(posedge in_clk) disable iff (!reset) restart == m_restart)
        else value_error("restart", $sampled(restart), $sampled(m_restart));

    //////////////////////////////
    // Stimulus

    task automatic wait_vsync(input logic level);
        int count;
        count = 0;
        while (vga_vs !== level && count < wait_limit) begin
            @(negedge in_clk);
            count++;
        end
        if (vga_vs !== level) begin
            $display("vga_vs did not reach %0b within %0d cycles", level, wait_limit);
            abort_run();
        end
    endtask

    task automatic send_packet(input int dx, input int dy, input logic left, input logic right);
        @(negedge in_clk);
        motion = '{dx: 9'(dx), dy: 9'(dy), left: left, right: right};
        motion_valid = 1'b1;
        @(negedge in_clk);
        motion_valid = 1'b0;
    endtask

    task automatic move_to(input int tx, input int ty);
        int tries;
        tries = 0;
        while ((m_x != tx || m_y != ty) && tries < 8) begin
            send_packet(limit_step(tx - m_x), limit_step(m_y - ty), 1'b0, 1'b0);
            tries++;
        end
        if (m_x != tx || m_y != ty) begin
            $display("pointer model did not reach (%0d, %0d)", tx, ty);
            abort_run();
        end
    endtask

    initial begin
        in_clk = 1'b0;
        reset = 1'b0;
        motion = '0;
        motion_valid = 1'b0;
        score = '0;
        void'($urandom(82));
        repeat (3) @(negedge in_clk);
        reset = 1'b1;

        // New score and pointer during each vertical sync
        for (int frame = 0; frame < 8; frame++) begin
            wait_vsync(1'b0);
            score = (frame == 3) ? 10'd1000 :
                    ((frame == 7) ? 10'd1023 : 10'($urandom_range(999, 0)));
            case (frame % 4)
                0: begin
                    repeat (4) send_packet(int'($urandom_range(511, 0)) - 256,
                                           int'($urandom_range(511, 0)) - 256,
                                           1'($urandom_range(1, 0)),
                                           1'($urandom_range(1, 0)));
                end
                1: move_to(300, 240);
                2: begin
                    move_to(240, 128);
                    send_packet(0, 0, 1'b1, 1'b0);
                end
                default: begin
                    move_to(300, 355);
                    send_packet(0, 0, 1'b1, 1'b0);
                end
            endcase
            wait_vsync(1'b1);
        end
        wait_vsync(1'b0);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* end_screen.f */
logic/end_screen_pkg.sv
logic/raster_timing.sv
logic/banner_text.sv
logic/score_digits.sv
logic/pointer_tracker.sv
logic/pixel_mixer.sv
logic/end_screen_top.sv
test/end_screen_tb.sv

/* Makefile */
TOOL     = verilator
TOP      = end_screen_tb
FILELIST = end_screen.f
FLAGS    = --binary --timing --assert -Wno-fatal
LINT     = --lint-only --timing -Wall
LOG      = sim.log
PASS_MSG = Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
